// ==== flist.f ====
source/accel_pkg.sv
source/odr_capture.sv
source/sample_packer.sv
source/sample_fifo.sv
source/accel_fifo_top.sv
dv/tb_accel_fifo.sv

// ==== Bender.yml ====
package:
  name: accel_fifo

sources:
  - source/accel_pkg.sv
  - source/odr_capture.sv
  - source/sample_packer.sv
  - source/sample_fifo.sv
  - source/accel_fifo_top.sv
  - target: test
    files:
      - dv/tb_accel_fifo.sv

// ==== dv/tb_accel_fifo.sv ====
`timescale 1ns/1ps

module tb_accel_fifo;

   import accel_pkg::*;

   logic        clk_sys = 1'b0;
   logic        reset;
   logic        odr;
   sample_t     x_in;
   sample_t     y_in;
   sample_t     z_in;
   sample_t     temp_in;
   fifo_mode_t  fifo_mode;
   logic        fifo_temp;
   fifo_count_t watermark_level;
   logic        rd_valid;
   logic        rd_ready = 1'b0;
   fifo_word_t  rd_data;
   fifo_count_t entries;
   logic        watermark;
   logic        overrun;

   fifo_word_t  exp_q [$];
   fifo_word_t  exp_word;
   string       test_name = "reset";
   int          errors = 0;
   int          timeouts = 0;
   logic [31:0] stim_seed = 32'h3ee3_44ac;
   logic [31:0] rd_seed = 32'h3ee3_44ac;
   logic        read_en = 1'b0;
   logic        check_off = 1'b0;
   logic        check_full = 1'b0;
   logic        wm_expect;

   accel_fifo_top i_accel_fifo_top (.*);

   always #4 clk_sys = ~clk_sys;

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected watermark from the entry count and level
   assign wm_expect = (watermark_level != '0) && (entries >= watermark_level);

   assert property (@(posedge clk_sys) disable iff (reset) rd_valid == (entries != '0))
      else begin
         errors++;
         $display("Fail %s: rd_valid expected %0b actual %0b", test_name,
                  $sampled(entries != '0), $sampled(rd_valid));
      end

   // Only in cycles with no write and no read
   assert property (@(posedge clk_sys) disable iff (reset)
      !(rd_valid && rd_ready) && !i_accel_fifo_top.wr_valid && $stable(watermark_level)
      |-> watermark == wm_expect)
      else begin
         errors++;
         $display("Fail %s: watermark expected %0b actual %0b", test_name,
                  $sampled(wm_expect), $sampled(watermark));
      end

   assert property (@(posedge clk_sys) disable iff (reset)
      !$past(reset) && $past(overrun) |-> overrun)
      else begin
         errors++;
         $display("Fail %s: overrun expected 1 actual 0", test_name);
      end

   assert property (@(posedge clk_sys) disable iff (reset) check_off |-> entries == '0)
      else begin
         errors++;
         $display("Fail %s: entries expected 0 actual %0d", test_name, $sampled(entries));
      end

   assert property (@(posedge clk_sys) disable iff (reset)
      check_full |-> entries == fifo_count_t'(FIFO_DEPTH))
      else begin
         errors++;
         $display("Fail %s: entries expected %0d actual %0d", test_name, FIFO_DEPTH,
                  $sampled(entries));
      end

   assert property (@(posedge clk_sys) disable iff (reset) check_full |-> overrun)
      else begin
         errors++;
         $display("Fail %s: overrun expected 1 actual %0b", test_name, $sampled(overrun));
      end

   // Read side compare against the reference queue
   always @(posedge clk_sys) begin
      if (!reset && rd_valid && rd_ready) begin
         if (exp_q.size() == 0) begin
            errors++;
            $display("Word %h read in %s while none was expected", rd_data, test_name);
         end else begin
            exp_word = exp_q.pop_front();
            assert (rd_data == exp_word)
               else begin
                  errors++;
                  $display("Fail %s: expected %h actual %h", test_name, exp_word, rd_data);
               end
         end
      end
   end

   always @(negedge clk_sys) begin
      rd_seed  = lcg(rd_seed);
      rd_ready = read_en && rd_seed[16];
   end

   // Reference FIFO with the same full policy
   task automatic model_push(input fifo_word_t w);
      if (fifo_mode == MODE_OFF) begin
         return;
      end
      if (exp_q.size() == FIFO_DEPTH) begin
         if (fifo_mode == MODE_OLDEST) begin
            return;
         end
         void'(exp_q.pop_front());
      end
      exp_q.push_back(w);
   endtask

   task automatic send_sample();
      sample_t            v [4];
      axis_tag_t          tags [4];
      logic signed [13:0] ext;
      tags = '{TAG_X, TAG_Y, TAG_Z, TAG_TEMP};
      for (int i = 0; i < 4; i++) begin
         stim_seed = lcg(stim_seed);
         v[i] = stim_seed[27:16];
      end
      x_in    = v[0];
      y_in    = v[1];
      z_in    = v[2];
      temp_in = v[3];
      odr     = 1'b1;
      for (int i = 0; i < (fifo_temp ? 4 : 3); i++) begin
         ext = $signed(v[i]);
         model_push({tags[i], ext});
      end
      repeat (2) @(negedge clk_sys);
      odr = 1'b0;
      // Leaves room for the packer to finish
      repeat (12) @(negedge clk_sys);
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (2) @(negedge clk_sys);
      reset = 1'b0;
      exp_q.delete();
   endtask

   task automatic wait_drained(input int limit);
      int n;
      n = 0;
      while ((exp_q.size() != 0 || rd_valid) && n < limit) begin
         @(negedge clk_sys);
         n++;
      end
      if (exp_q.size() != 0 || rd_valid) begin
         timeouts++;
         $display("Timed out in %s waiting for the FIFO to drain, %0d words still expected",
                  test_name, exp_q.size());
      end
   endtask

   task automatic overfill(input fifo_mode_t mode);
      fifo_mode = mode;
      read_en   = 1'b0;
      repeat (12) send_sample();
      check_full = 1'b1;
      @(negedge clk_sys);
      check_full = 1'b0;
      read_en    = 1'b1;
      wait_drained(600);
   endtask

   initial begin
      reset           = 1'b1;
      odr             = 1'b0;
      x_in            = '0;
      y_in            = '0;
      z_in            = '0;
      temp_in         = '0;
      fifo_mode       = MODE_STREAM;
      fifo_temp       = 1'b0;
      watermark_level = fifo_count_t'(8);
      apply_reset();

      test_name = "stream_xyz";
      read_en   = 1'b1;
      repeat (6) send_sample();
      wait_drained(400);

      test_name = "stream_temp";
      fifo_temp = 1'b1;
      repeat (6) send_sample();
      wait_drained(400);

      test_name = "mode_off";
      fifo_mode = MODE_OFF;
      check_off = 1'b1;
      repeat (4) send_sample();
      check_off = 1'b0;

      test_name       = "oldest_full";
      fifo_temp       = 1'b0;
      watermark_level = fifo_count_t'(20);
      overfill(MODE_OLDEST);

      test_name = "stream_full";
      apply_reset();
      overfill(MODE_STREAM);

      $display("Run complete: %0d check errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Watchdog for the whole run
   initial begin
      #2ms;
      $display("Run did not finish within the time limit");
      $display("Simulation FAILED");
      $finish;
   end

endmodule

// ==== source/accel_fifo_top.sv ====
`timescale 1ns/1ps

module accel_fifo_top (
   input  logic                   clk_sys,
   input  logic                   reset,
   input  logic                   odr,
   input  accel_pkg::sample_t     x_in,
   input  accel_pkg::sample_t     y_in,
   input  accel_pkg::sample_t     z_in,
   input  accel_pkg::sample_t     temp_in,
   input  accel_pkg::fifo_mode_t  fifo_mode,
   input  logic                   fifo_temp,
   input  accel_pkg::fifo_count_t watermark_level,
   output logic                   rd_valid,
   input  logic                   rd_ready,
   output accel_pkg::fifo_word_t  rd_data,
   output accel_pkg::fifo_count_t entries,
   output logic                   watermark,
   output logic                   overrun
);

   import accel_pkg::*;

   // Capture to packer
   logic       smp_valid;
   logic       smp_ready;
   sample_t    smp_x;
   sample_t    smp_y;
   sample_t    smp_z;
   sample_t    smp_temp;

   // Packer to FIFO
   logic       wr_valid;
   logic       wr_ready;
   fifo_word_t wr_data;

   odr_capture i_odr_capture (
      .clk_sys   (clk_sys),
      .reset     (reset),
      .odr       (odr),
      .x_in      (x_in),
      .y_in      (y_in),
      .z_in      (z_in),
      .temp_in   (temp_in),
      .smp_valid (smp_valid),
      .smp_ready (smp_ready),
      .smp_x     (smp_x),
      .smp_y     (smp_y),
      .smp_z     (smp_z),
      .smp_temp  (smp_temp)
   );

   sample_packer i_sample_packer (
      .clk_sys   (clk_sys),
      .reset     (reset),
      .fifo_mode (fifo_mode),
      .fifo_temp (fifo_temp),
      .smp_valid (smp_valid),
      .smp_ready (smp_ready),
      .smp_x     (smp_x),
      .smp_y     (smp_y),
      .smp_z     (smp_z),
      .smp_temp  (smp_temp),
      .wr_valid  (wr_valid),
      .wr_ready  (wr_ready),
      .wr_data   (wr_data)
   );

   sample_fifo i_sample_fifo (
      .clk_sys         (clk_sys),
      .reset           (reset),
      .fifo_mode       (fifo_mode),
      .watermark_level (watermark_level),
      .wr_valid        (wr_valid),
      .wr_ready        (wr_ready),
      .wr_data         (wr_data),
      .rd_valid        (rd_valid),
      .rd_ready        (rd_ready),
      .rd_data         (rd_data),
      .entries         (entries),
      .watermark       (watermark),
      .overrun         (overrun)
   );

endmodule

// ==== source/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo (
   input  logic                   clk_sys,
   input  logic                   reset,
   input  accel_pkg::fifo_mode_t  fifo_mode,
   input  accel_pkg::fifo_count_t watermark_level,
   input  logic                   wr_valid,
   output logic                   wr_ready,
   input  accel_pkg::fifo_word_t  wr_data,
   output logic                   rd_valid,
   input  logic                   rd_ready,
   output accel_pkg::fifo_word_t  rd_data,
   output accel_pkg::fifo_count_t entries,
   output logic                   watermark,
   output logic                   overrun
);

   import accel_pkg::*;

   fifo_word_t       mem [FIFO_DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   fifo_count_t      count;
   fifo_count_t      count_next;

   logic             is_stream;
   logic             full;
   logic             wr_fire;
   logic             rd_fire;
   logic             overflow;
   logic             drop_old;
   logic             do_write;
   logic             do_read;

   assign is_stream = (fifo_mode == MODE_STREAM) || (fifo_mode == MODE_TRIGGER);
   assign full      = (count == fifo_count_t'(FIFO_DEPTH));

   // Always accepting unless off, full policy decides the outcome
   assign wr_ready  = (fifo_mode != MODE_OFF);
   assign wr_fire   = wr_valid && wr_ready;

   assign rd_valid  = (count != '0);
   assign rd_data   = mem[rd_ptr];
   assign rd_fire   = rd_valid && rd_ready;

   // Full with no read in the same cycle to make room
   assign overflow  = wr_fire && full && !rd_fire;

   // Stream mode evicts the oldest entry, oldest mode drops the new word
   assign drop_old  = overflow && is_stream;
   assign do_write  = wr_fire && (!overflow || is_stream);
   assign do_read   = rd_fire || drop_old;

   always_comb begin
      count_next = count;
      case ({do_write, do_read})
         2'b10:   count_next = count + 1'b1;
         2'b01:   count_next = count - 1'b1;
         default: count_next = count;
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (do_write) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count_next;
      end
   end

   // Flags
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         watermark <= 1'b0;
         overrun   <= 1'b0;
      end else begin
         watermark <= (watermark_level != '0) && (count_next >= watermark_level);
         if (overflow) begin
            overrun <= 1'b1;
         end
      end
   end

   assign entries = count;

endmodule

// ==== source/sample_packer.sv ====
`timescale 1ns/1ps

module sample_packer (
   input  logic                   clk_sys,
   input  logic                   reset,
   input  accel_pkg::fifo_mode_t  fifo_mode,
   input  logic                   fifo_temp,
   input  logic                   smp_valid,
   output logic                   smp_ready,
   input  accel_pkg::sample_t     smp_x,
   input  accel_pkg::sample_t     smp_y,
   input  accel_pkg::sample_t     smp_z,
   input  accel_pkg::sample_t     smp_temp,
   output logic                   wr_valid,
   input  logic                   wr_ready,
   output accel_pkg::fifo_word_t  wr_data
);

   import accel_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_emit_x,
      st_emit_y,
      st_emit_z,
      st_emit_temp
   } state_t;

   state_t  state;
   state_t  state_next;

   sample_t lat_x;
   sample_t lat_y;
   sample_t lat_z;
   sample_t lat_temp;
   logic    lat_temp_en;

   logic    accept;
   logic    word_done;

   // Tag on top, then bit 11 copied twice ahead of the raw value
   function automatic fifo_word_t make_word(axis_tag_t tag, sample_t value);
      return {tag, value[11], value[11], value};
   endfunction

   // Off mode swallows samples so the capture stage never stalls
   assign smp_ready = (state == st_idle) || (fifo_mode == MODE_OFF);
   assign accept    = (state == st_idle) && smp_valid && (fifo_mode != MODE_OFF);
   assign wr_valid  = (state != st_idle);
   assign word_done = wr_valid && wr_ready;

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (accept) begin
               state_next = st_emit_x;
            end
         end
         st_emit_x: begin
            if (word_done) begin
               state_next = st_emit_y;
            end
         end
         st_emit_y: begin
            if (word_done) begin
               state_next = st_emit_z;
            end
         end
         st_emit_z: begin
            if (word_done) begin
               state_next = lat_temp_en ? st_emit_temp : st_idle;
            end
         end
         st_emit_temp: begin
            if (word_done) begin
               state_next = st_idle;
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk_sys) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   // Sample and temp enable frozen for the whole word sequence
   always_ff @(posedge clk_sys) begin
      if (accept) begin
         lat_x       <= smp_x;
         lat_y       <= smp_y;
         lat_z       <= smp_z;
         lat_temp    <= smp_temp;
         lat_temp_en <= fifo_temp;
      end
   end

   always_comb begin
      case (state)
         st_emit_x:    wr_data = make_word(TAG_X, lat_x);
         st_emit_y:    wr_data = make_word(TAG_Y, lat_y);
         st_emit_z:    wr_data = make_word(TAG_Z, lat_z);
         st_emit_temp: wr_data = make_word(TAG_TEMP, lat_temp);
         default:      wr_data = '0;
      endcase
   end

endmodule

// ==== source/odr_capture.sv ====
`timescale 1ns/1ps

module odr_capture (
   input  logic               clk_sys,
   input  logic               reset,
   input  logic               odr,
   input  accel_pkg::sample_t x_in,
   input  accel_pkg::sample_t y_in,
   input  accel_pkg::sample_t z_in,
   input  accel_pkg::sample_t temp_in,
   output logic               smp_valid,
   input  logic               smp_ready,
   output accel_pkg::sample_t smp_x,
   output accel_pkg::sample_t smp_y,
   output accel_pkg::sample_t smp_z,
   output accel_pkg::sample_t smp_temp
);

   logic odr_meta;
   logic odr_sync;
   logic odr_prev;
   logic odr_tick;

   // Two-flop synchronizer plus one delayed copy for edge detection
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         odr_meta <= 1'b0;
         odr_sync <= 1'b0;
         odr_prev <= 1'b0;
      end else begin
         odr_meta <= odr;
         odr_sync <= odr_meta;
         odr_prev <= odr_sync;
      end
   end

   // Single-cycle pulse on a synchronized rising edge
   assign odr_tick = odr_sync & ~odr_prev;

   // A fresh tick wins over a pending transfer
   always_ff @(posedge clk_sys) begin
      if (reset) begin
         smp_valid <= 1'b0;
      end else if (odr_tick) begin
         smp_valid <= 1'b1;
      end else if (smp_ready) begin
         smp_valid <= 1'b0;
      end
   end

   // Newest sample overwrites one not yet taken
   always_ff @(posedge clk_sys) begin
      if (odr_tick) begin
         smp_x    <= x_in;
         smp_y    <= y_in;
         smp_z    <= z_in;
         smp_temp <= temp_in;
      end
   end

endmodule

// ==== source/accel_pkg.sv ====
package accel_pkg;

   // One raw 12-bit two's-complement measurement
   typedef logic [11:0] sample_t;

   // FIFO entry layout: [15:14] axis tag, [13:0] sign-extended value
   typedef logic [15:0] fifo_word_t;

   typedef logic [1:0] axis_tag_t;

   localparam axis_tag_t TAG_X    = 2'd0;
   localparam axis_tag_t TAG_Y    = 2'd1;
   localparam axis_tag_t TAG_Z    = 2'd2;
   localparam axis_tag_t TAG_TEMP = 2'd3;

   // FIFO operating modes
   typedef logic [1:0] fifo_mode_t;

   localparam fifo_mode_t MODE_OFF     = 2'd0;
   localparam fifo_mode_t MODE_OLDEST  = 2'd1;
   localparam fifo_mode_t MODE_STREAM  = 2'd2;
   // Trigger mode is handled like stream here
   localparam fifo_mode_t MODE_TRIGGER = 2'd3;

   // Word storage, kept a power of two so pointers wrap on their own
   localparam int FIFO_DEPTH = 32;
   localparam int PTR_W      = $clog2(FIFO_DEPTH);

   // Must hold the value FIFO_DEPTH itself
   localparam int COUNT_W    = $clog2(FIFO_DEPTH + 1);

   typedef logic [COUNT_W-1:0] fifo_count_t;

endpackage
